/* hdl/corep.sv */
// core package for the memory dependence prediction subsystem
// widths, table types, update struct and pc slicing helpers
package corep;

    // ----------------------------------------------------------------------
    // sizes

    localparam int FETCH_LANES = 4;
    localparam int MDPT_SETS   = 512;

    localparam int ASID_WIDTH       = 9;
    localparam int PC38_WIDTH       = 38;
    localparam int FETCH_LANE_WIDTH = $clog2(FETCH_LANES);
    localparam int FETCH_IDX_WIDTH  = PC38_WIDTH - FETCH_LANE_WIDTH;
    localparam int MDPT_IDX_WIDTH   = $clog2(MDPT_SETS);
    localparam int MDP_WIDTH        = 8;

    // ----------------------------------------------------------------------
    // types

    typedef logic [ASID_WIDTH-1:0] asid_t;

    // pc with the two always-zero bits dropped
    typedef logic [PC38_WIDTH-1:0] pc38_t;

    typedef logic [FETCH_IDX_WIDTH-1:0]  fetch_idx_t;
    typedef logic [FETCH_LANE_WIDTH-1:0] fetch_lane_t;

    typedef logic [MDPT_IDX_WIDTH-1:0] mdpt_idx_t;
    typedef logic [MDP_WIDTH-1:0]      mdp_t;

    // one prediction per entry, no extra state
    typedef mdp_t mdpt_entry_t;

    // whole set, lane 0 in the low byte
    typedef mdpt_entry_t [FETCH_LANES-1:0] mdpt_set_t;

    // training update from the load/store unit
    typedef struct packed {
        pc38_t pc38;
        mdp_t  mdp;
    } mdpt_update_t;

    // ----------------------------------------------------------------------
    // pc slicing

    // fetch block index = upper pc38 bits
    function automatic fetch_idx_t fetch_idx_bits(input pc38_t pc38);
        return pc38[PC38_WIDTH-1:FETCH_LANE_WIDTH];
    endfunction

    // lane within the fetch block = low pc38 bits
    function automatic fetch_lane_t fetch_lane_bits(input pc38_t pc38);
        return pc38[FETCH_LANE_WIDTH-1:0];
    endfunction

endpackage

/* hdl/bram_1rport_1wport.sv */
// block ram with one registered read port and one byte-enabled write port
`timescale 1ns/10ps

module bram_1rport_1wport #(
    parameter int INNER_WIDTH = 32,
    parameter int OUTER_WIDTH = 512
) (
    input  logic                           CLK,
    input  logic                           rst,

    // read port
    input  logic                           ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0] rindex,
    output logic [INNER_WIDTH-1:0]         rdata,

    // write port
    input  logic [INNER_WIDTH/8-1:0]       wen_byte,
    input  logic [$clog2(OUTER_WIDTH)-1:0] windex,
    input  logic [INNER_WIDTH-1:0]         wdata
);

    localparam int BYTES = INNER_WIDTH / 8;

    // storage
    logic [INNER_WIDTH-1:0] mem [OUTER_WIDTH];

    // ----------------------------------------------------------------------
    // write port

    always_ff @(posedge CLK) begin
        for (int b = 0; b < BYTES; b++) begin
            if (wen_byte[b]) begin
                mem[windex][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    // ----------------------------------------------------------------------
    // read port

    // old data on a same-edge collision, holds when ren is low
    always_ff @(posedge CLK) begin
        if (rst) begin
            rdata <= '0;
        end else if (ren) begin
            rdata <= mem[rindex];
        end
    end

endmodule

/* hdl/mdpt.sv */
// memory dependence prediction table
// asid-hashed set reads for fetch, lane writes for training, full-set clear writes
`timescale 1ns/10ps

module mdpt
    import corep::*;
(
    // seq
    input  logic         CLK,
    input  logic         rst,

    // arch state
    input  asid_t        arch_asid,

    // fetch read, response one cycle later
    input  logic         read_req_valid,
    input  fetch_idx_t   read_req_fetch_idx,
    output mdpt_set_t    read_resp_mdp_by_lane,

    // training drain from the update queue
    input  logic         drain_valid,
    input  mdpt_update_t drain_update,

    // clear walk
    input  logic         clear_valid,
    input  mdpt_idx_t    clear_index
);

    localparam int ENTRY_BYTES = $bits(mdpt_entry_t) / 8;

    // ----------------------------------------------------------------------
    // hash

    // low fetch index bits xor asid
    function automatic mdpt_idx_t index_hash(input fetch_idx_t fetch_idx, input asid_t asid);
        return fetch_idx[MDPT_IDX_WIDTH-1:0] ^ mdpt_idx_t'(asid);
    endfunction

    // ----------------------------------------------------------------------
    // signals

    // bram read side
    logic        bram_ren;
    mdpt_idx_t   bram_rindex;
    mdpt_set_t   bram_rdata;

    // bram write side
    logic [FETCH_LANES-1:0][ENTRY_BYTES-1:0] bram_wen_byte;
    mdpt_idx_t                               bram_windex;
    mdpt_set_t                               bram_wdata;

    // update decode
    mdpt_idx_t   update_index;
    fetch_lane_t update_lane;

    // ----------------------------------------------------------------------
    // read

    always_comb begin
        bram_ren    = read_req_valid;
        bram_rindex = index_hash(read_req_fetch_idx, arch_asid);
    end

    assign read_resp_mdp_by_lane = bram_rdata;

    // ----------------------------------------------------------------------
    // write

    always_comb begin
        update_index = index_hash(fetch_idx_bits(drain_update.pc38), arch_asid);
        update_lane  = fetch_lane_bits(drain_update.pc38);

        // default is the drained update, mdp copied into every lane
        bram_wen_byte = '0;
        bram_windex   = update_index;
        for (int lane = 0; lane < FETCH_LANES; lane++) begin
            bram_wdata[lane] = drain_update.mdp;
        end

        // clear wins, whole set to zero
        if (clear_valid) begin
            bram_wen_byte = '1;
            bram_windex   = clear_index;
            bram_wdata    = '0;
        end else if (drain_valid) begin
            bram_wen_byte[update_lane] = '1;
        end
    end

    // ----------------------------------------------------------------------
    // table array

    bram_1rport_1wport #(
        .INNER_WIDTH($bits(mdpt_set_t)),
        .OUTER_WIDTH(MDPT_SETS)
    ) mdpt_array_bram (
        .CLK      (CLK),
        .rst      (rst),
        .ren      (bram_ren),
        .rindex   (bram_rindex),
        .rdata    (bram_rdata),
        .wen_byte (bram_wen_byte),
        .windex   (bram_windex),
        .wdata    (bram_wdata)
    );

endmodule

/* hdl/mdpt_ctrl.sv */
// table control: asid register and clear walk over every set
`timescale 1ns/10ps

module mdpt_ctrl
    import corep::*;
(
    input  logic      CLK,
    input  logic      rst,

    // asid config write
    input  logic      asid_wr_valid,
    input  asid_t     asid_wr_data,
    output asid_t     arch_asid,

    // clear steering into the table
    output logic      clear_valid,
    output mdpt_idx_t clear_index,

    // status
    output logic      clearing,
    output logic      ready
);

    typedef enum logic {
        CLEAR,
        IDLE
    } state_t;

    state_t    state;
    mdpt_idx_t set_count;

    // ----------------------------------------------------------------------
    // asid register

    // new asid visible from the write edge on
    always_ff @(posedge CLK) begin
        if (rst) begin
            arch_asid <= '0;
        end else if (asid_wr_valid) begin
            arch_asid <= asid_wr_data;
        end
    end

    // ----------------------------------------------------------------------
    // clear walk

    always_ff @(posedge CLK) begin
        if (rst) begin
            state     <= CLEAR;
            set_count <= '0;
        end else if (asid_wr_valid) begin
            // restart from set 0, also mid-walk
            state     <= CLEAR;
            set_count <= '0;
        end else begin
            case (state)
                CLEAR: begin
                    if (set_count == mdpt_idx_t'(MDPT_SETS - 1)) begin
                        state <= IDLE;
                    end
                    set_count <= set_count + 1'b1;
                end
                IDLE: begin
                    set_count <= '0;
                end
                default: begin
                    state <= CLEAR;
                end
            endcase
        end
    end

    // one set per cycle while walking
    assign clear_valid = (state == CLEAR);
    assign clear_index = set_count;

    // queue holds its entries while walking
    assign clearing    = (state == CLEAR);
    assign ready       = (state == IDLE);

endmodule

/* hdl/mdpt_update_queue.sv */
// credit-managed training update queue, drains one update per cycle into the table
`timescale 1ns/10ps

module mdpt_update_queue
    import corep::*;
#(
    parameter int UPDATE_CREDITS = 4
) (
    input  logic         CLK,
    input  logic         rst,

    // load/store side
    input  logic         update_valid,
    input  mdpt_update_t update,
    output logic         update_credit,

    // table side
    input  logic         clearing,
    output logic         drain_valid,
    output mdpt_update_t drain_update
);

    localparam int PTR_WIDTH   = (UPDATE_CREDITS > 1) ? $clog2(UPDATE_CREDITS) : 1;
    localparam int COUNT_WIDTH = $clog2(UPDATE_CREDITS + 1);

    typedef logic [PTR_WIDTH-1:0]   ptr_t;
    typedef logic [COUNT_WIDTH-1:0] count_t;

    // ----------------------------------------------------------------------
    // storage and pointers

    mdpt_update_t entries [UPDATE_CREDITS];
    ptr_t         wptr;
    ptr_t         rptr;
    count_t       count;

    logic         push;
    logic         pop;

    // wrap that also works for non power of two depths
    function automatic ptr_t ptr_incr(input ptr_t ptr);
        if (ptr == ptr_t'(UPDATE_CREDITS - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // sender credits guarantee a free slot
    assign push = update_valid;

    // no drain while the table is being cleared
    assign pop  = (count != '0) && !clearing;

    always_ff @(posedge CLK) begin
        if (push) begin
            entries[wptr] <= update;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wptr <= ptr_incr(wptr);
            end
            if (pop) begin
                rptr <= ptr_incr(rptr);
            end
            count <= count + count_t'(push) - count_t'(pop);
        end
    end

    // ----------------------------------------------------------------------
    // outputs

    assign drain_valid   = pop;
    assign drain_update  = entries[rptr];

    // one credit back per entry leaving
    assign update_credit = pop;

endmodule

/* hdl/mdp_unit.sv */
// memory dependence prediction unit
// control block, training update queue and prediction table
`timescale 1ns/10ps

module mdp_unit
    import corep::*;
#(
    parameter int UPDATE_CREDITS = 4
) (
    input  logic         CLK,
    input  logic         rst,

    // fetch side
    input  logic         read_req_valid,
    input  fetch_idx_t   read_req_fetch_idx,
    output mdpt_set_t    read_resp_mdp_by_lane,

    // load/store side
    input  logic         update_valid,
    input  mdpt_update_t update,
    output logic         update_credit,

    // config
    input  logic         asid_wr_valid,
    input  asid_t        asid_wr_data,
    output asid_t        arch_asid,
    output logic         ready
);

    // ----------------------------------------------------------------------
    // internal links

    logic         clear_valid;
    mdpt_idx_t    clear_index;
    logic         clearing;
    logic         drain_valid;
    mdpt_update_t drain_update;

    mdpt_ctrl ctrl_i (
        .CLK           (CLK),
        .rst           (rst),
        .asid_wr_valid (asid_wr_valid),
        .asid_wr_data  (asid_wr_data),
        .arch_asid     (arch_asid),
        .clear_valid   (clear_valid),
        .clear_index   (clear_index),
        .clearing      (clearing),
        .ready         (ready)
    );

    mdpt_update_queue #(
        .UPDATE_CREDITS(UPDATE_CREDITS)
    ) queue_i (
        .CLK           (CLK),
        .rst           (rst),
        .update_valid  (update_valid),
        .update        (update),
        .update_credit (update_credit),
        .clearing      (clearing),
        .drain_valid   (drain_valid),
        .drain_update  (drain_update)
    );

    mdpt mdpt_i (
        .CLK                   (CLK),
        .rst                   (rst),
        .arch_asid             (arch_asid),
        .read_req_valid        (read_req_valid),
        .read_req_fetch_idx    (read_req_fetch_idx),
        .read_resp_mdp_by_lane (read_resp_mdp_by_lane),
        .drain_valid           (drain_valid),
        .drain_update          (drain_update),
        .clear_valid           (clear_valid),
        .clear_index           (clear_index)
    );

endmodule

/* verification/mdp_unit_tb.sv */
// testbench for the memory dependence prediction unit
// table and credit reference models, property checks, lcg stimulus
`timescale 1ns/10ps

module mdp_unit_tb
    import corep::*;
();

    localparam int UPDATE_CREDITS  = 4;
    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 16;
    localparam int TRAINED         = 8;
    localparam int DIRECTED_CYCLES = 800;
    localparam int RANDOM_CYCLES   = 3000;
    localparam int ASID_WRITES     = 2;

    // twice the expected run with two walks per asid write
    localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + MDPT_SETS + DIRECTED_CYCLES
        + RANDOM_CYCLES + ASID_WRITES * 2 * MDPT_SETS);

    logic         CLK;
    logic         rst;
    logic         read_req_valid;
    fetch_idx_t   read_req_fetch_idx;
    mdpt_set_t    read_resp_mdp_by_lane;
    logic         update_valid;
    mdpt_update_t update;
    logic         update_credit;
    logic         asid_wr_valid;
    asid_t        asid_wr_data;
    asid_t        arch_asid;
    logic         ready;

    // reference state
    mdpt_set_t    model_table [MDPT_SETS];
    asid_t        model_asid;
    mdpt_set_t    pending_set;
    mdpt_set_t    exp_resp;
    asid_t        exp_asid;
    int           credits;
    int           walk_age;
    int           drain_wait;
    logic [31:0]  lcg_state;
    fetch_idx_t   trained [TRAINED];
    string        test_name;

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    mdp_unit #(
        .UPDATE_CREDITS(UPDATE_CREDITS)
    ) dut_i (
        .CLK                   (CLK),
        .rst                   (rst),
        .read_req_valid        (read_req_valid),
        .read_req_fetch_idx    (read_req_fetch_idx),
        .read_resp_mdp_by_lane (read_resp_mdp_by_lane),
        .update_valid          (update_valid),
        .update                (update),
        .update_credit         (update_credit),
        .asid_wr_valid         (asid_wr_valid),
        .asid_wr_data          (asid_wr_data),
        .arch_asid             (arch_asid),
        .ready                 (ready)
    );

    // ----------------------------------------------------------------------
    // helpers

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic fetch_idx_t random_fetch_idx();
        logic [63:0] r;
        r = {next_random(), next_random()};
        return r[FETCH_IDX_WIDTH-1:0];
    endfunction

    // set index = low 9 fetch index bits xor asid
    function automatic mdpt_idx_t table_index(input fetch_idx_t fetch_idx, input asid_t asid);
        return fetch_idx[8:0] ^ asid;
    endfunction

    // sender credits once the current edge has been taken
    function automatic int credits_after_edge();
        return credits + int'(update_credit) - int'(update_valid);
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic next_cycle();
        @(posedge CLK);
        read_req_valid <= 1'b0;
        update_valid   <= 1'b0;
        asid_wr_valid  <= 1'b0;
    endtask

    task automatic drive_read(input fetch_idx_t fetch_idx);
        read_req_valid     <= 1'b1;
        read_req_fetch_idx <= fetch_idx;
        pending_set        <= model_table[table_index(fetch_idx, model_asid)];
    endtask

    // pc38 holds the fetch index in bits 37:2 and the lane in bits 1:0
    task automatic drive_update(input pc38_t pc38, input mdp_t mdp);
        update_valid <= 1'b1;
        update.pc38  <= pc38;
        update.mdp   <= mdp;
        model_table[table_index(pc38[37:2], model_asid)][pc38[1:0]] = mdp;
    endtask

    task automatic issue_read(input fetch_idx_t fetch_idx);
        next_cycle();
        drive_read(fetch_idx);
    endtask

    task automatic issue_update(input pc38_t pc38, input mdp_t mdp);
        next_cycle();
        while (credits_after_edge() == 0) begin
            next_cycle();
        end
        drive_update(pc38, mdp);
    endtask

    task automatic wait_full_credits();
        do begin
            next_cycle();
        end while (credits_after_edge() != UPDATE_CREDITS);
    endtask

    task automatic wait_ready();
        do begin
            next_cycle();
        end while (!ready);
    endtask

    task automatic write_asid(input asid_t asid);
        next_cycle();
        asid_wr_valid <= 1'b1;
        asid_wr_data  <= asid;
        model_asid = asid;
        for (int s = 0; s < MDPT_SETS; s++) begin
            model_table[s] = '0;
        end
    endtask

    // ----------------------------------------------------------------------
    // tracking of credits, clear walk, read response and asid

    always @(posedge CLK) begin
        if (rst) begin
            credits    <= UPDATE_CREDITS;
            walk_age   <= 0;
            drain_wait <= 0;
            exp_resp   <= '0;
            exp_asid   <= '0;
        end else begin
            credits <= credits + int'(update_credit) - int'(update_valid);
            if (asid_wr_valid) begin
                walk_age <= 0;
                exp_asid <= asid_wr_data;
            end else if (walk_age < MDPT_SETS) begin
                walk_age <= walk_age + 1;
            end
            // response holds between requests
            if (read_req_valid) begin
                exp_resp <= pending_set;
            end
            // cycles spent waiting on outstanding credits with nothing new sent
            if (update_valid || !ready || credits == UPDATE_CREDITS) begin
                drain_wait <= 0;
            end else begin
                drain_wait <= drain_wait + 1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // checks

    assert property (@(posedge CLK) disable iff (rst) ready == (walk_age >= MDPT_SETS))
        else stop_with_failure($sformatf("Error: %s ready expected %0d actual %0d",
            test_name, walk_age >= MDPT_SETS, ready));

    assert property (@(posedge CLK) disable iff (rst) read_resp_mdp_by_lane == exp_resp)
        else stop_with_failure($sformatf("Error: %s read_data expected %h actual %h",
            test_name, exp_resp, read_resp_mdp_by_lane));

    assert property (@(posedge CLK) disable iff (rst) credits >= 0 && credits <= UPDATE_CREDITS)
        else stop_with_failure($sformatf("Error: %s credits expected 0 to %0d actual %0d",
            test_name, UPDATE_CREDITS, credits));

    assert property (@(posedge CLK) disable iff (rst) !ready |-> !update_credit)
        else stop_with_failure($sformatf("Error: %s update_credit expected 0 actual %0d",
            test_name, update_credit));

    assert property (@(posedge CLK) disable iff (rst) drain_wait <= UPDATE_CREDITS)
        else stop_with_failure($sformatf("Error: %s credit_return expected %0d actual %0d",
            test_name, UPDATE_CREDITS, credits));

    assert property (@(posedge CLK) disable iff (rst) arch_asid == exp_asid)
        else stop_with_failure($sformatf("Error: %s arch_asid expected %h actual %h",
            test_name, exp_asid, arch_asid));

    // ----------------------------------------------------------------------
    // test sequence

    initial begin
        logic [31:0] r;
        rst                = 1'b1;
        read_req_valid     = 1'b0;
        read_req_fetch_idx = '0;
        update_valid       = 1'b0;
        update             = '0;
        asid_wr_valid      = 1'b0;
        asid_wr_data       = '0;
        lcg_state          = 32'h0942_3e34;
        model_asid         = '0;
        pending_set        = '0;
        test_name          = "clear_timing";
        for (int s = 0; s < MDPT_SETS; s++) begin
            model_table[s] = '0;
        end
        repeat (RESET_CYCLES) @(posedge CLK);
        rst <= 1'b0;

        // fresh table reads back as zero
        wait_ready();
        for (int i = 0; i < 16; i++) begin
            issue_read(random_fetch_idx());
        end

        // fill lanes one at a time and read back after each drain
        test_name = "lane_update";
        for (int i = 0; i < TRAINED; i++) begin
            trained[i] = random_fetch_idx();
            for (int lane = FETCH_LANES - 1; lane >= 0; lane--) begin
                issue_update({trained[i], 2'(lane)}, mdp_t'(next_random()));
                wait_full_credits();
                issue_read(trained[i]);
            end
        end

        // spaced reads then back to back reads
        test_name = "read_hold";
        for (int i = 0; i < TRAINED; i++) begin
            issue_read(trained[i]);
            repeat (3) next_cycle();
        end
        for (int i = 0; i < TRAINED; i++) begin
            issue_read(trained[TRAINED - 1 - i]);
        end

        // updates sent while the walk runs stay queued
        test_name = "credit_burst";
        wait_full_credits();
        write_asid(9'h1a5);
        repeat (2) next_cycle();
        for (int i = 0; i < UPDATE_CREDITS; i++) begin
            issue_update({trained[i], 2'(i)}, mdp_t'(next_random()));
        end
        wait_ready();
        wait_full_credits();

        test_name = "asid_change";
        for (int i = 0; i < TRAINED; i++) begin
            issue_read(trained[i]);
        end
        wait_full_credits();
        write_asid(asid_t'(next_random()));
        wait_ready();
        for (int i = 0; i < TRAINED; i++) begin
            issue_read(trained[i]);
        end
        for (int i = 0; i < TRAINED; i++) begin
            r = next_random();
            issue_update({trained[i], r[1:0]}, r[15:8]);
            wait_full_credits();
            issue_read(trained[i]);
        end

        // reads only with every credit home
        test_name = "random_mix";
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            next_cycle();
            r = next_random();
            if (r[2:0] < 3'd3 && credits_after_edge() == UPDATE_CREDITS) begin
                drive_read(trained[r[10:8]]);
            end else if (r[2:0] >= 3'd5 && credits_after_edge() > 0) begin
                drive_update({trained[r[10:8]], r[12:11]}, r[31:24]);
            end
        end
        wait_full_credits();
        repeat (4) next_cycle();
        $display("Test OK");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        stop_with_failure("the test sequence did not finish in time");
    end

endmodule

/* vlog.f */
hdl/corep.sv
hdl/bram_1rport_1wport.sv
hdl/mdpt.sv
hdl/mdpt_ctrl.sv
hdl/mdpt_update_queue.sv
hdl/mdp_unit.sv
verification/mdp_unit_tb.sv

/* Makefile */
# Verilator build for the memory dependence prediction unit testbench

VERILATOR  ?= verilator
TOP        ?= mdp_unit_tb
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 4
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
EXTRA      ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) $(EXTRA) \
		-f $(FILELIST) --top-module $(TOP)

# exit status of the run is the test result
sim:
	$(VERILATOR) $(SIM_FLAGS) $(EXTRA) -j $(JOBS) \
		-f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
